// File: design/rocc_link_pkg.sv
// shared widths, command codes, packet layout and rs1 views for the rocc to manycore bridge
package rocc_link_pkg;

  //////////////////////////////////////////////////
  // widths

  // rocket side
  localparam int unsigned rocc_data_width_gp   = 32;
  localparam int unsigned rocc_addr_width_gp   = 32;
  localparam int unsigned rocc_reg_id_width_gp = 5;
  localparam int unsigned rocc_funct7_width_gp = 7;

  // manycore side, word address and its byte form
  localparam int unsigned mc_addr_width_gp      = 16;
  localparam int unsigned mc_byte_addr_width_gp = mc_addr_width_gp + 2;
  localparam int unsigned mc_cord_width_gp      = 4;
  localparam int unsigned mc_mask_width_gp      = rocc_data_width_gp / 8;

  // segment fills the rocket address above the manycore byte address
  localparam int unsigned seg_addr_width_gp = rocc_addr_width_gp - mc_byte_addr_width_gp;

  //////////////////////////////////////////////////
  // command and opcode encodings

  typedef enum logic [rocc_funct7_width_gp-1:0] {
    e_cmd_core_reset = 7'd0,
    e_cmd_seg_addr   = 7'd1,
    e_cmd_write      = 7'd2,
    e_cmd_read       = 7'd3
  } rocc_funct7_e;

  typedef enum logic [4:0] {
    e_mem_load  = 5'd0,
    e_mem_store = 5'd1
  } rocc_mem_cmd_e;

  typedef enum logic [1:0] {
    e_op_remote_load  = 2'd0,
    e_op_remote_store = 2'd1
  } mc_op_e;

  //////////////////////////////////////////////////
  // outgoing packet

  // msb first: op, mask, addr, data, dst x, dst y, src x, src y
  localparam int unsigned mc_packet_width_gp = $bits(mc_op_e)
                                             + mc_mask_width_gp
                                             + mc_addr_width_gp
                                             + rocc_data_width_gp
                                             + 4 * mc_cord_width_gp;

  //////////////////////////////////////////////////
  // rs1 operand

  // seg_addr reads a rocket byte address, write and read
  // read a manycore coordinate plus word address
  typedef union packed {
    struct packed {
      logic [seg_addr_width_gp-1:0]     seg;
      logic [mc_byte_addr_width_gp-1:0] byte_off;
    } rocket;
    struct packed {
      logic [rocc_data_width_gp-2*mc_cord_width_gp-mc_addr_width_gp-1:0] unused;
      logic [mc_cord_width_gp-1:0] y_cord;
      logic [mc_cord_width_gp-1:0] x_cord;
      logic [mc_addr_width_gp-1:0] word_addr;
    } mc;
  } rocc_rs1_u;

endpackage

// File: design/rocc_cmd_ctrl.sv
// decodes rocc core commands into manycore reset, segment loads and remote packets
module rocc_cmd_ctrl (
  input  logic                                         rocket_clk_i,
  input  logic                                         rocket_reset_i,
  input  logic [rocc_link_pkg::mc_cord_width_gp-1:0]   my_x_i,
  input  logic [rocc_link_pkg::mc_cord_width_gp-1:0]   my_y_i,

  // core command
  input  logic                                         core_cmd_valid_i,
  input  logic [rocc_link_pkg::rocc_funct7_width_gp-1:0] core_cmd_funct7_i,
  input  logic [rocc_link_pkg::rocc_reg_id_width_gp-1:0] core_cmd_rd_i,
  input  rocc_link_pkg::rocc_rs1_u                     core_cmd_rs1_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] core_cmd_rs2_i,
  output logic                                         core_cmd_ready_o,

  // core response
  output logic                                         core_resp_valid_o,
  output logic [rocc_link_pkg::rocc_reg_id_width_gp-1:0] core_resp_rd_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] core_resp_data_o,

  // outgoing packet
  output logic                                         mc_out_v_o,
  output logic [rocc_link_pkg::mc_packet_width_gp-1:0] mc_out_packet_o,
  input  logic                                         mc_out_ready_i,

  // read return
  input  logic                                         mc_returned_v_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_returned_data_i,

  output logic [rocc_link_pkg::seg_addr_width_gp-1:0]  seg_addr_o,
  output logic                                         read_busy_o,
  output logic                                         reset_manycore_r_o
);

  import rocc_link_pkg::*;

  logic is_core_reset;
  logic is_seg_addr;
  logic is_write;
  logic is_read;
  logic is_mc_cmd;
  logic cmd_fire;
  logic read_take;

  logic                            reset_manycore_r;
  logic [seg_addr_width_gp-1:0]    seg_addr_r;
  logic [rocc_reg_id_width_gp-1:0] wb_rd_r;
  logic                            read_in_flight_r;

  mc_op_e                          pkt_op;
  logic [rocc_data_width_gp-1:0]   pkt_data;

  //////////////////////////////////////////////////
  // decode and accept

  assign is_core_reset = core_cmd_funct7_i == e_cmd_core_reset;
  assign is_seg_addr   = core_cmd_funct7_i == e_cmd_seg_addr;
  assign is_write      = core_cmd_funct7_i == e_cmd_write;
  assign is_read       = core_cmd_funct7_i == e_cmd_read;
  assign is_mc_cmd     = is_write | is_read;

  // only manycore accesses wait on the outgoing link
  assign core_cmd_ready_o = ~read_in_flight_r & (~is_mc_cmd | mc_out_ready_i);
  assign cmd_fire         = core_cmd_valid_i & core_cmd_ready_o;

  //////////////////////////////////////////////////
  // manycore reset pulse and segment register

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      reset_manycore_r <= 1'b0;
    end else begin
      reset_manycore_r <= cmd_fire & is_core_reset;
    end
  end

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      seg_addr_r <= '0;
    end else if (cmd_fire && is_seg_addr) begin
      seg_addr_r <= core_cmd_rs1_i.rocket.seg;
    end
  end

  //////////////////////////////////////////////////
  // read tracking

  // a read counts as issued once the link takes its packet
  assign read_take = mc_out_v_o & mc_out_ready_i & is_read;

  always_ff @(posedge rocket_clk_i) begin
    if (read_take) begin
      wb_rd_r <= core_cmd_rd_i;
    end
  end

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      read_in_flight_r <= 1'b0;
    end else if (mc_returned_v_i) begin
      read_in_flight_r <= 1'b0;
    end else if (read_take) begin
      read_in_flight_r <= 1'b1;
    end
  end

  // core is always ready, so the write back is not held
  assign core_resp_valid_o = mc_returned_v_i;
  assign core_resp_rd_o    = wb_rd_r;
  assign core_resp_data_o  = mc_returned_data_i;

  //////////////////////////////////////////////////
  // packet encoding

  assign pkt_op   = is_write ? e_op_remote_store : e_op_remote_load;
  assign pkt_data = is_write ? core_cmd_rs2_i : '0;

  assign mc_out_v_o = core_cmd_valid_i & is_mc_cmd & ~read_in_flight_r;

  // word access only, mask is all ones
  assign mc_out_packet_o = {pkt_op,
                            {mc_mask_width_gp{1'b1}},
                            core_cmd_rs1_i.mc.word_addr,
                            pkt_data,
                            core_cmd_rs1_i.mc.x_cord,
                            core_cmd_rs1_i.mc.y_cord,
                            my_x_i,
                            my_y_i};

  assign seg_addr_o         = seg_addr_r;
  assign read_busy_o        = read_in_flight_r;
  assign reset_manycore_r_o = reset_manycore_r;

endmodule

// File: design/rocc_mem_bridge.sv
// turns incoming manycore requests into rocket memory requests with one request outstanding
module rocc_mem_bridge (
  input  logic                                         rocket_clk_i,
  input  logic                                         rocket_reset_i,
  input  logic [rocc_link_pkg::seg_addr_width_gp-1:0]  seg_addr_i,

  // incoming manycore request
  input  logic                                         mc_in_v_i,
  input  logic [rocc_link_pkg::mc_addr_width_gp-1:0]   mc_in_addr_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_in_data_i,
  input  logic [rocc_link_pkg::mc_mask_width_gp-1:0]   mc_in_mask_i,
  input  logic                                         mc_in_we_i,
  output logic                                         mc_in_yumi_o,

  // load result back to the manycore
  output logic                                         mc_returning_v_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_returning_data_o,

  // rocket memory request
  output logic                                         mem_req_valid_o,
  output logic [rocc_link_pkg::rocc_addr_width_gp-1:0] mem_req_addr_o,
  output rocc_link_pkg::rocc_mem_cmd_e                 mem_req_cmd_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] mem_req_data_o,
  input  logic                                         mem_req_ready_i,

  // rocket memory response
  input  logic                                         mem_resp_valid_i,
  input  rocc_link_pkg::rocc_mem_cmd_e                 mem_resp_cmd_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mem_resp_data_i,

  output logic                                         credit_busy_o
);

  import rocc_link_pkg::*;

  logic credit_taken_r;
  logic mem_req_fire;

  //////////////////////////////////////////////////
  // single request credit

  // responses may come back out of order, so only one goes out
  assign mem_req_valid_o = mc_in_v_i & ~credit_taken_r;
  assign mem_req_fire    = mem_req_valid_o & mem_req_ready_i;
  assign mc_in_yumi_o    = mem_req_fire;

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      credit_taken_r <= 1'b0;
    end else if (mem_resp_valid_i) begin
      credit_taken_r <= 1'b0;
    end else if (mem_req_fire) begin
      credit_taken_r <= 1'b1;
    end
  end

  assign credit_busy_o = credit_taken_r;

  //////////////////////////////////////////////////
  // request fields

  // segment on top, then the word address in bytes
  assign mem_req_addr_o = {seg_addr_i, mc_in_addr_i, 2'b00};
  assign mem_req_cmd_o  = mc_in_we_i ? e_mem_store : e_mem_load;

  // rocket port is word wide, disabled byte lanes go out as zero
  always_comb begin
    for (int i = 0; i < mc_mask_width_gp; i++) begin
      mem_req_data_o[8*i +: 8] = mc_in_mask_i[i] ? mc_in_data_i[8*i +: 8] : 8'h00;
    end
  end

  //////////////////////////////////////////////////
  // load results

  assign mc_returning_v_o    = mem_resp_valid_i & (mem_resp_cmd_i == e_mem_load);
  assign mc_returning_data_o = mem_resp_data_i;

endmodule

// File: design/rocc_link_top.sv
// top level of the rocc to manycore bridge, connects command control and memory bridge
module rocc_link_top (
  input  logic                                         rocket_clk_i,
  input  logic                                         rocket_reset_i,
  input  logic [rocc_link_pkg::mc_cord_width_gp-1:0]   my_x_i,
  input  logic [rocc_link_pkg::mc_cord_width_gp-1:0]   my_y_i,

  // core command
  input  logic                                         core_cmd_valid_i,
  input  logic [rocc_link_pkg::rocc_funct7_width_gp-1:0] core_cmd_funct7_i,
  input  logic [rocc_link_pkg::rocc_reg_id_width_gp-1:0] core_cmd_rd_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] core_cmd_rs1_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] core_cmd_rs2_i,
  output logic                                         core_cmd_ready_o,

  // core response
  output logic                                         core_resp_valid_o,
  output logic [rocc_link_pkg::rocc_reg_id_width_gp-1:0] core_resp_rd_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] core_resp_data_o,

  // outgoing packet
  output logic                                         mc_out_v_o,
  output logic [rocc_link_pkg::mc_packet_width_gp-1:0] mc_out_packet_o,
  input  logic                                         mc_out_ready_i,

  // read return
  input  logic                                         mc_returned_v_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_returned_data_i,

  // incoming manycore request
  input  logic                                         mc_in_v_i,
  input  logic [rocc_link_pkg::mc_addr_width_gp-1:0]   mc_in_addr_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_in_data_i,
  input  logic [rocc_link_pkg::mc_mask_width_gp-1:0]   mc_in_mask_i,
  input  logic                                         mc_in_we_i,
  output logic                                         mc_in_yumi_o,

  // load result to the manycore
  output logic                                         mc_returning_v_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] mc_returning_data_o,

  // rocket memory request
  output logic                                         mem_req_valid_o,
  output logic [rocc_link_pkg::rocc_addr_width_gp-1:0] mem_req_addr_o,
  output rocc_link_pkg::rocc_mem_cmd_e                 mem_req_cmd_o,
  output logic [rocc_link_pkg::rocc_data_width_gp-1:0] mem_req_data_o,
  input  logic                                         mem_req_ready_i,

  // rocket memory response
  input  logic                                         mem_resp_valid_i,
  input  rocc_link_pkg::rocc_mem_cmd_e                 mem_resp_cmd_i,
  input  logic [rocc_link_pkg::rocc_data_width_gp-1:0] mem_resp_data_i,

  // status
  output logic                                         reset_manycore_r_o,
  output logic                                         acc_busy_o
);

  import rocc_link_pkg::*;

  logic [seg_addr_width_gp-1:0] seg_addr;
  logic                         read_busy;
  logic                         credit_busy;

  //////////////////////////////////////////////////
  // core command side

  rocc_cmd_ctrl i_cmd_ctrl (
    .rocket_clk_i       (rocket_clk_i),
    .rocket_reset_i     (rocket_reset_i),
    .my_x_i             (my_x_i),
    .my_y_i             (my_y_i),
    .core_cmd_valid_i   (core_cmd_valid_i),
    .core_cmd_funct7_i  (core_cmd_funct7_i),
    .core_cmd_rd_i      (core_cmd_rd_i),
    .core_cmd_rs1_i     (core_cmd_rs1_i),
    .core_cmd_rs2_i     (core_cmd_rs2_i),
    .core_cmd_ready_o   (core_cmd_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rd_o     (core_resp_rd_o),
    .core_resp_data_o   (core_resp_data_o),
    .mc_out_v_o         (mc_out_v_o),
    .mc_out_packet_o    (mc_out_packet_o),
    .mc_out_ready_i     (mc_out_ready_i),
    .mc_returned_v_i    (mc_returned_v_i),
    .mc_returned_data_i (mc_returned_data_i),
    .seg_addr_o         (seg_addr),
    .read_busy_o        (read_busy),
    .reset_manycore_r_o (reset_manycore_r_o)
  );

  //////////////////////////////////////////////////
  // manycore to rocket memory side

  rocc_mem_bridge i_mem_bridge (
    .rocket_clk_i        (rocket_clk_i),
    .rocket_reset_i      (rocket_reset_i),
    .seg_addr_i          (seg_addr),
    .mc_in_v_i           (mc_in_v_i),
    .mc_in_addr_i        (mc_in_addr_i),
    .mc_in_data_i        (mc_in_data_i),
    .mc_in_mask_i        (mc_in_mask_i),
    .mc_in_we_i          (mc_in_we_i),
    .mc_in_yumi_o        (mc_in_yumi_o),
    .mc_returning_v_o    (mc_returning_v_o),
    .mc_returning_data_o (mc_returning_data_o),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_req_addr_o      (mem_req_addr_o),
    .mem_req_cmd_o       (mem_req_cmd_o),
    .mem_req_data_o      (mem_req_data_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .mem_resp_valid_i    (mem_resp_valid_i),
    .mem_resp_cmd_i      (mem_resp_cmd_i),
    .mem_resp_data_i     (mem_resp_data_i),
    .credit_busy_o       (credit_busy)
  );

  // busy while either direction has something outstanding
  assign acc_busy_o = read_busy | credit_busy;

endmodule

// File: verification/tb_rocc_link.sv
// testbench for the rocc to manycore bridge, compiled as the simulation top with the design files
module tb_rocc_link;
  timeunit 1ns;
  timeprecision 1ps;

  import rocc_link_pkg::*;

  typedef logic [69:0] val_t;

  localparam int num_tests = 6;
  localparam logic [6:0] cmd_core_reset = 7'd0;
  localparam logic [6:0] cmd_seg_addr   = 7'd1;
  localparam logic [6:0] cmd_write      = 7'd2;
  localparam logic [6:0] cmd_read       = 7'd3;

  // names follow the DUT ports so the instance connects by name
  logic        rocket_clk_i, rocket_reset_i;
  logic [3:0]  my_x_i, my_y_i, mc_in_mask_i;
  logic        core_cmd_valid_i, core_cmd_ready_o, core_resp_valid_o;
  logic [6:0]  core_cmd_funct7_i;
  logic [4:0]  core_cmd_rd_i, core_resp_rd_o;
  logic [31:0] core_cmd_rs1_i, core_cmd_rs2_i, core_resp_data_o;
  logic        mc_out_v_o, mc_out_ready_i, mc_returned_v_i;
  logic [69:0] mc_out_packet_o;
  logic [31:0] mc_returned_data_i, mc_in_data_i, mc_returning_data_o;
  logic        mc_in_v_i, mc_in_we_i, mc_in_yumi_o, mc_returning_v_o;
  logic [15:0] mc_in_addr_i;
  logic        mem_req_valid_o, mem_req_ready_i, mem_resp_valid_i;
  logic [31:0] mem_req_addr_o, mem_req_data_o, mem_resp_data_i;
  rocc_mem_cmd_e mem_req_cmd_o, mem_resp_cmd_i;
  logic        reset_manycore_r_o, acc_busy_o;

  // reference state kept from the stimulus
  logic        read_pending, credit_taken;
  logic        reset_fire, seg_fire, read_fire, req_fire;
  logic [4:0]  exp_rd;
  logic [13:0] exp_seg;
  val_t        exp_packet;
  int          err_count;
  int          test_count;

  rocc_link_top i_dut (.*);

  initial begin
    rocket_clk_i = 1'b0;
    forever #10 rocket_clk_i = ~rocket_clk_i;
  end

  // op, mask, word addr, data, dst x, dst y, src x, src y
  function automatic val_t pack_expected(input logic [6:0] f, input logic [31:0] a,
                                         input logic [31:0] d, input logic [3:0] x,
                                         input logic [3:0] y);
    logic [1:0]  op;
    logic [31:0] data;
    op   = (f == cmd_write) ? 2'd1 : 2'd0;
    data = (f == cmd_write) ? d : 32'd0;
    return {op, 4'hf, a[15:0], data, a[19:16], a[23:20], x, y};
  endfunction

  assign exp_packet = pack_expected(core_cmd_funct7_i, core_cmd_rs1_i, core_cmd_rs2_i,
                                    my_x_i, my_y_i);
  assign reset_fire = core_cmd_valid_i & core_cmd_ready_o & (core_cmd_funct7_i == cmd_core_reset);
  assign seg_fire   = core_cmd_valid_i & core_cmd_ready_o & (core_cmd_funct7_i == cmd_seg_addr);
  assign read_fire  = core_cmd_valid_i & core_cmd_ready_o & (core_cmd_funct7_i == cmd_read);
  assign req_fire   = mc_in_v_i & mem_req_ready_i & ~credit_taken;

  always @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      read_pending <= 1'b0;
      credit_taken <= 1'b0;
      exp_rd       <= '0;
      exp_seg      <= '0;
    end else begin
      if (mc_returned_v_i) begin
        read_pending <= 1'b0;
      end else if (read_fire) begin
        read_pending <= 1'b1;
      end
      if (read_fire) begin
        exp_rd <= core_cmd_rd_i;
      end
      if (seg_fire) begin
        exp_seg <= core_cmd_rs1_i[31:18];
      end
      if (mem_resp_valid_i) begin
        credit_taken <= 1'b0;
      end else if (req_fire) begin
        credit_taken <= 1'b1;
      end
    end
  end

  task automatic flag_mismatch(input string sig, input val_t exp_val, input val_t got_val);
    err_count++;
    $display("ERR %s exp 0x%0h got 0x%0h at %0t", sig, exp_val, got_val, $time);
  endtask

  task automatic flag_failure(input string what);
    err_count++;
    $display("check failed at %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // checks

  reset_pulse_on: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      reset_fire |=> reset_manycore_r_o)
    else flag_mismatch("reset_manycore_r_o", val_t'(1'b1), val_t'($sampled(reset_manycore_r_o)));
  reset_pulse_off: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      reset_manycore_r_o |=> !reset_manycore_r_o)
    else flag_failure("manycore reset pulse lasted longer than one cycle");
  reset_pulse_cause: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      reset_manycore_r_o |-> $past(reset_fire))
    else flag_failure("manycore reset pulse without an accepted core_reset command");
  packet_fields: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_out_v_o |-> mc_out_packet_o == exp_packet)
    else flag_mismatch("mc_out_packet_o", $sampled(exp_packet), $sampled(mc_out_packet_o));
  packet_valid: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_out_v_o == (core_cmd_valid_i && !read_pending
                     && (core_cmd_funct7_i == cmd_write || core_cmd_funct7_i == cmd_read)))
    else flag_mismatch("mc_out_v_o", val_t'(!$sampled(mc_out_v_o)), val_t'($sampled(mc_out_v_o)));
  backpressure_ready: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_out_v_o && !mc_out_ready_i |-> !core_cmd_ready_o)
    else flag_mismatch("core_cmd_ready_o", val_t'(1'b0), val_t'($sampled(core_cmd_ready_o)));
  backpressure_hold: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_out_v_o && !mc_out_ready_i |=> $stable(mc_out_packet_o))
    else flag_failure("packet changed while mc_out_ready_i was low");
  read_blocks: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      read_pending |-> !core_cmd_ready_o)
    else flag_mismatch("core_cmd_ready_o", val_t'(1'b0), val_t'($sampled(core_cmd_ready_o)));
  busy_level: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      acc_busy_o == (credit_taken || read_pending))
    else flag_mismatch("acc_busy_o", val_t'(!$sampled(acc_busy_o)), val_t'($sampled(acc_busy_o)));
  resp_valid: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      core_resp_valid_o == mc_returned_v_i)
    else flag_mismatch("core_resp_valid_o", val_t'($sampled(mc_returned_v_i)),
                       val_t'($sampled(core_resp_valid_o)));
  resp_rd: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_returned_v_i |-> core_resp_rd_o == exp_rd)
    else flag_mismatch("core_resp_rd_o", val_t'($sampled(exp_rd)), val_t'($sampled(core_resp_rd_o)));
  resp_data: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_returned_v_i |-> core_resp_data_o == mc_returned_data_i)
    else flag_mismatch("core_resp_data_o", val_t'($sampled(mc_returned_data_i)),
                       val_t'($sampled(core_resp_data_o)));
  req_valid: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mem_req_valid_o == (mc_in_v_i && !credit_taken))
    else flag_mismatch("mem_req_valid_o", val_t'(!$sampled(mem_req_valid_o)),
                       val_t'($sampled(mem_req_valid_o)));
  req_addr: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mem_req_valid_o |-> mem_req_addr_o == {exp_seg, mc_in_addr_i, 2'b00})
    else flag_mismatch("mem_req_addr_o", val_t'($sampled({exp_seg, mc_in_addr_i, 2'b00})),
                       val_t'($sampled(mem_req_addr_o)));
  req_cmd: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mem_req_valid_o |-> mem_req_cmd_o == (mc_in_we_i ? e_mem_store : e_mem_load))
    else flag_mismatch("mem_req_cmd_o", val_t'($sampled(mc_in_we_i)), val_t'($sampled(mem_req_cmd_o)));
  req_data: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mem_req_valid_o |-> mem_req_data_o == mc_in_data_i)
    else flag_mismatch("mem_req_data_o", val_t'($sampled(mc_in_data_i)),
                       val_t'($sampled(mem_req_data_o)));
  yumi_level: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_in_yumi_o == req_fire)
    else flag_mismatch("mc_in_yumi_o", val_t'($sampled(req_fire)), val_t'($sampled(mc_in_yumi_o)));
  returning_valid: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_returning_v_o == (mem_resp_valid_i && mem_resp_cmd_i == e_mem_load))
    else flag_mismatch("mc_returning_v_o", val_t'(!$sampled(mc_returning_v_o)),
                       val_t'($sampled(mc_returning_v_o)));
  returning_data: assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
      mc_returning_v_o |-> mc_returning_data_o == mem_resp_data_i)
    else flag_mismatch("mc_returning_data_o", val_t'($sampled(mem_resp_data_i)),
                       val_t'($sampled(mc_returning_data_o)));

  //////////////////////////////////////////////////
  // stimulus helpers, each starts and ends on a rising edge

  task automatic drive_cmd(input logic [6:0] f, input logic [31:0] a, input logic [31:0] d);
    core_cmd_valid_i  <= 1'b1;
    core_cmd_funct7_i <= f;
    core_cmd_rd_i     <= 5'($urandom);
    core_cmd_rs1_i    <= a;
    core_cmd_rs2_i    <= d;
  endtask

  task automatic wait_cmd_accept();
    @(negedge rocket_clk_i);
    while (!core_cmd_ready_o) begin
      @(negedge rocket_clk_i);
    end
    @(posedge rocket_clk_i);
    core_cmd_valid_i <= 1'b0;
  endtask

  task automatic present_request(input logic we, input logic [15:0] addr);
    mc_in_v_i    <= 1'b1;
    mc_in_we_i   <= we;
    mc_in_addr_i <= addr;
    mc_in_data_i <= $urandom;
  endtask

  task automatic wait_yumi();
    @(negedge rocket_clk_i);
    while (!mc_in_yumi_o) begin
      @(negedge rocket_clk_i);
    end
    @(posedge rocket_clk_i);
  endtask

  // returns on the edge that samples the response, credit is free from there on
  task automatic send_mem_resp(input rocc_mem_cmd_e cmd);
    repeat ($urandom_range(4, 1)) @(posedge rocket_clk_i);
    mem_resp_valid_i <= 1'b1;
    mem_resp_cmd_i   <= cmd;
    mem_resp_data_i  <= $urandom;
    @(posedge rocket_clk_i);
    mem_resp_valid_i <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
  endtask

  initial begin
    repeat (num_tests * 200) @(posedge rocket_clk_i);
    $display("timeout: tests did not finish within %0d cycles", num_tests * 200);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int errs;
    void'($urandom(15013));
    err_count  = 0;
    test_count = 0;
    rocket_reset_i     <= 1'b1;
    my_x_i             <= 4'h3;
    my_y_i             <= 4'h5;
    core_cmd_valid_i   <= 1'b0;
    core_cmd_funct7_i  <= cmd_core_reset;
    core_cmd_rd_i      <= '0;
    core_cmd_rs1_i     <= '0;
    core_cmd_rs2_i     <= '0;
    mc_out_ready_i     <= 1'b1;
    mc_returned_v_i    <= 1'b0;
    mc_returned_data_i <= '0;
    mc_in_v_i          <= 1'b0;
    mc_in_addr_i       <= '0;
    mc_in_data_i       <= '0;
    mc_in_mask_i       <= 4'hf;
    mc_in_we_i         <= 1'b0;
    mem_req_ready_i    <= 1'b1;
    mem_resp_valid_i   <= 1'b0;
    mem_resp_cmd_i     <= e_mem_load;
    mem_resp_data_i    <= '0;
    repeat (8) @(posedge rocket_clk_i);
    rocket_reset_i <= 1'b0;
    @(negedge rocket_clk_i);
    assert (!(reset_manycore_r_o | mc_out_v_o | mem_req_valid_o | mc_in_yumi_o
              | core_resp_valid_o | acc_busy_o))
      else flag_failure("an output was high right after reset");
    @(posedge rocket_clk_i);

    errs = err_count;
    drive_cmd(cmd_core_reset, $urandom, $urandom);
    wait_cmd_accept();
    repeat (3) @(posedge rocket_clk_i);
    report_test("manycore reset pulse", errs);

    errs = err_count;
    drive_cmd(cmd_write, $urandom, $urandom);
    wait_cmd_accept();
    report_test("core write packet", errs);

    // link stalls for a few cycles while the write waits
    errs = err_count;
    mc_out_ready_i <= 1'b0;
    drive_cmd(cmd_write, $urandom, $urandom);
    repeat ($urandom_range(6, 3)) @(posedge rocket_clk_i);
    mc_out_ready_i <= 1'b1;
    wait_cmd_accept();
    report_test("write back-pressure", errs);

    errs = err_count;
    drive_cmd(cmd_read, $urandom, $urandom);
    wait_cmd_accept();
    repeat ($urandom_range(8, 3)) @(posedge rocket_clk_i);
    mc_returned_v_i    <= 1'b1;
    mc_returned_data_i <= $urandom;
    @(posedge rocket_clk_i);
    mc_returned_v_i <= 1'b0;
    repeat (2) @(posedge rocket_clk_i);
    report_test("core read and write back", errs);

    errs = err_count;
    drive_cmd(cmd_seg_addr, $urandom, $urandom);
    wait_cmd_accept();
    mem_req_ready_i <= 1'b0;
    present_request(1'b1, 16'($urandom));
    repeat (2) @(posedge rocket_clk_i);
    mem_req_ready_i <= 1'b1;
    wait_yumi();
    mc_in_v_i <= 1'b0;
    send_mem_resp(e_mem_store);
    report_test("segment and incoming store", errs);

    // second request waits on the credit of the first
    errs = err_count;
    present_request(1'b1, 16'($urandom));
    wait_yumi();
    present_request(1'b0, 16'($urandom));
    repeat ($urandom_range(6, 3)) @(posedge rocket_clk_i);
    send_mem_resp(e_mem_store);
    wait_yumi();
    mc_in_v_i <= 1'b0;
    send_mem_resp(e_mem_load);
    report_test("single credit and load result", errs);

    repeat (2) @(posedge rocket_clk_i);
    $display("tests run %0d, errors %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
design/rocc_link_pkg.sv
design/rocc_cmd_ctrl.sv
design/rocc_mem_bridge.sv
design/rocc_link_top.sv
verification/tb_rocc_link.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_rocc_link
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
